// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module ulaTb -f list.f -o ulaTb

run: compile
	@out="$$(./obj_dir/ulaTb)"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// File: design/colourMerge.sv
`timescale 1ns/1ns

module colourMerge (
   input  logic                     clk7,
   input  logic                     rst_n,
   input  ulaVideoPkg::rgb9_t       stdRgb,
   input  ulaVideoPkg::plusColour_t plusRgb,
   input  logic                     ulaPlusEnabled,
   output ulaVideoPkg::colour3_t    r,
   output ulaVideoPkg::colour3_t    g,
   output ulaVideoPkg::colour3_t    b
);

   ulaVideoPkg::rgb9_t mergedRgb;
   ulaVideoPkg::rgb9_t rgbOut;

   // Blue B1 B0 widened to B1 B0 B1
   assign mergedRgb = ulaPlusEnabled ? {plusRgb, plusRgb[1]} : stdRgb;

   // DAC register
   always_ff @(posedge clk7) begin
      if (!rst_n)
         rgbOut <= '0;
      else
         rgbOut <= mergedRgb;
   end

   // GGGRRRBBB split
   assign g = rgbOut[8:6];
   assign r = rgbOut[5:3];
   assign b = rgbOut[2:0];

endmodule

// File: design/cpuPorts.sv
`timescale 1ns/1ns
`include "ula_settings.svh"

module cpuPorts (
   input  logic                     clk7,
   input  logic                     rst_n,
   input  ulaCpuPkg::cpuAddr_t      a,
   input  logic                     iorqN,
   input  logic                     rdN,
   input  logic                     wrN,
   input  ulaCpuPkg::cpuByte_t      din,
   input  logic                     ear,
   input  logic [4:0]               kbd,
   input  logic                     issue2Keyboard,
   input  ulaVideoPkg::plusColour_t paletteEntry,
   output ulaCpuPkg::cpuByte_t      dout,
   output logic                     mic,
   output logic                     spk,
   output ulaVideoPkg::colour3_t    border,
   output logic                     paletteWrite,
   output ulaCpuPkg::paletteIdx_t   paletteIdx,
   output logic                     ulaPlusEnabled
);

   ulaCpuPkg::plusReg_t plusReg;
   logic                ioWrite;
   logic                ioRead;
   logic                plusDataWrite;
   logic                earIn;

   // Z80 strobes, sampled on every pixel clock
   assign ioWrite = !iorqN && !wrN;
   assign ioRead  = !iorqN && !rdN;

   assign plusDataWrite = ioWrite && (a == `PLUS_DATA_PORT);
   assign paletteWrite  = plusDataWrite && !plusReg[6];
   assign paletteIdx    = plusReg[5:0];

   //////////////////////////////
   // Port writes
   //////////////////////////////

   // 0xFE on any even address
   // Bits 2..0 border, bit 3 mic, bit 4 speaker
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         border <= `BORDER_RESET;
         mic    <= 1'b0;
         spk    <= 1'b0;
      end else if (ioWrite && !a[0]) begin
         border <= din[2:0];
         {spk, mic} <= din[4:3];
      end
   end

   // ULAplus register and config bit
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         plusReg        <= '0;
         ulaPlusEnabled <= 1'b0;
      end else begin
         if (ioWrite && (a == `PLUS_ADDR_PORT))
            plusReg <= din[6:0];
         // Data port reaches config only with bit 6 set
         if (plusDataWrite && plusReg[6])
            ulaPlusEnabled <= din[0];
      end
   end

   //////////////////////////////
   // Port reads
   //////////////////////////////

   // Issue 2 boards also hear mic on EAR
   always_comb begin
      if (issue2Keyboard)
         earIn = ear ^ (spk | mic);
      else
         earIn = ear ^ spk;
   end

   // Idle bus reads back as 0xFF
   always_comb begin
      dout = 8'hFF;
      if (ioRead) begin
         if (!a[0])
            dout = {1'b1, earIn, 1'b1, kbd};
         else if (a == `PLUS_ADDR_PORT)
            dout = {1'b0, plusReg};
         else if (a == `PLUS_DATA_PORT && !plusReg[6])
            dout = paletteEntry;
         else if (a == `PLUS_DATA_PORT)
            dout = {7'b0000000, ulaPlusEnabled};
      end
   end

endmodule

// File: design/plusColour.sv
`timescale 1ns/1ns

module plusColour (
   input  logic                     clk7,
   input  logic                     paletteWrite,
   input  ulaCpuPkg::paletteIdx_t   paletteIdx,
   input  ulaCpuPkg::cpuByte_t      din,
   input  ulaVideoPkg::attr_t       attrNext,
   input  logic                     attrOutLoad,
   input  logic                     pixel,
   output ulaVideoPkg::plusColour_t plusRgb,
   output ulaVideoPkg::plusColour_t paletteEntry
);

   ulaVideoPkg::plusColour_t palette [64];
   ulaCpuPkg::paletteIdx_t   paperIdx;
   ulaCpuPkg::paletteIdx_t   inkIdx;
   ulaVideoPkg::plusColour_t paperColour;
   ulaVideoPkg::plusColour_t inkColour;

   //////////////////////////////
   // Palette RAM
   //////////////////////////////

   // CPU side write, 64 x GGGRRRBB
   always_ff @(posedge clk7) begin
      if (paletteWrite)
         palette[paletteIdx] <= din;
   end

   // Readback at the register index
   assign paletteEntry = palette[paletteIdx];

   //////////////////////////////
   // Attribute lookup
   //////////////////////////////

   // Flash and bright pick one of four 16-entry groups
   // Paper in the upper 8, ink in the lower 8
   assign paperIdx = {attrNext[7:6], 1'b1, attrNext[5:3]};
   assign inkIdx   = {attrNext[7:6], 1'b0, attrNext[2:0]};

   // Held for the whole cell, like the standard attribute
   always_ff @(posedge clk7) begin
      if (attrOutLoad) begin
         paperColour <= palette[paperIdx];
         inkColour   <= palette[inkIdx];
      end
   end

   // No flash inversion in ULAplus mode
   assign plusRgb = pixel ? inkColour : paperColour;

endmodule

// File: design/rasterTiming.sv
`timescale 1ns/1ns
`include "ula_settings.svh"

module rasterTiming (
   input  logic                  clk7,
   input  logic                  rst_n,
   output ulaVideoPkg::vramAddr_t va,
   output logic                  bitmapLoad,
   output logic                  attrLoad,
   output logic                  serialLoad,
   output logic                  videoEnable,
   output logic                  attrOutLoad,
   output logic                  frameTick,
   output logic                  intN
);

   // Display trails the fetch by one 8-pixel cell
   localparam ulaVideoPkg::hCount_t fetchLead = 9'd8;

   ulaVideoPkg::hCount_t hCount;
   ulaVideoPkg::vCount_t vCount;
   logic [4:0]           columnAddr;
   logic                 inPaper;
   logic                 fetchSlot;
   logic                 bitmapAddr;
   logic                 attrAddr;

   //////////////////////////////
   // Raster counters
   //////////////////////////////

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         hCount <= '0;
         vCount <= '0;
      end else if (hCount == ulaVideoPkg::hCount_t'(`H_TOTAL - 1)) begin
         hCount <= '0;
         // Next line, or back to the top
         if (vCount == ulaVideoPkg::vCount_t'(`V_TOTAL - 1))
            vCount <= '0;
         else
            vCount <= vCount + 1'b1;
      end else begin
         hCount <= hCount + 1'b1;
      end
   end

   // Column address, taken ahead of each fetch pair
   always_ff @(posedge clk7) begin
      if (!rst_n)
         columnAddr <= '0;
      else if (hCount[2:0] == 3'd3)
         columnAddr <= hCount[7:3];
   end

   //////////////////////////////
   // Fetch and display strobes
   //////////////////////////////

   assign inPaper = (hCount <= ulaVideoPkg::hCount_t'(`H_PAPER_END)) &&
                    (vCount <= ulaVideoPkg::vCount_t'(`V_PAPER_END));

   // Upper half of each 16-pixel group
   // Bitmap slots 8,9,12,13 and attribute slots 10,11,14,15
   assign fetchSlot  = inPaper && hCount[3];
   assign bitmapAddr = fetchSlot && !hCount[1];
   assign attrAddr   = fetchSlot && hCount[1];
   assign bitmapLoad = bitmapAddr && hCount[0];
   assign attrLoad   = attrAddr && hCount[0];

   // Paper window shifted by the fetch lead
   assign videoEnable = (hCount >= fetchLead) &&
                        (hCount <= ulaVideoPkg::hCount_t'(`H_PAPER_END) + fetchLead) &&
                        (vCount <= ulaVideoPkg::vCount_t'(`V_PAPER_END));

   // New cell every 8 pixels
   assign attrOutLoad = (hCount[2:0] == 3'd4);
   assign serialLoad  = attrOutLoad && videoEnable;

   // Interleaved bitmap address or linear attribute address
   always_comb begin
      if (bitmapAddr)
         va = {1'b0, vCount[7:6], vCount[2:0], vCount[5:3], columnAddr};
      else if (attrAddr)
         va = {4'b0110, vCount[7:3], columnAddr};
      else
         va = '0;
   end

   //////////////////////////////
   // Frame interrupt
   //////////////////////////////

   assign frameTick = (vCount == ulaVideoPkg::vCount_t'(`INT_LINE)) && (hCount == '0);

   assign intN = !((vCount == ulaVideoPkg::vCount_t'(`INT_LINE)) &&
                   (hCount >= ulaVideoPkg::hCount_t'(`INT_FIRST)) &&
                   (hCount <= ulaVideoPkg::hCount_t'(`INT_LAST)));

endmodule

// File: design/stdColour.sv
`timescale 1ns/1ns

module stdColour (
   input  logic               clk7,
   input  logic               rst_n,
   input  ulaVideoPkg::attr_t attr,
   input  logic               pixel,
   input  logic               frameTick,
   output ulaVideoPkg::rgb9_t stdRgb
);

   // Channel levels
   localparam ulaVideoPkg::colour3_t lvlNone = 3'b000;
   localparam ulaVideoPkg::colour3_t lvlHalf = 3'b101;
   localparam ulaVideoPkg::colour3_t lvlFull = 3'b111;

   logic [4:0]           flashCount;
   logic                 flashPixel;
   ulaVideoPkg::igrb_t   colourIdx;

   // Flash phase toggles every 16 frames
   always_ff @(posedge clk7) begin
      if (!rst_n)
         flashCount <= '0;
      else if (frameTick)
         flashCount <= flashCount + 1'b1;
   end

   // Swap ink and paper in the flash phase
   assign flashPixel = pixel ^ (attr[7] & flashCount[4]);

   assign colourIdx = flashPixel ? {attr[6], attr[2:0]} : {attr[6], attr[5:3]};

   // IGRB to GGGRRRBBB
   always_comb begin
      case (colourIdx)
         4'd1:    stdRgb = {lvlNone, lvlNone, lvlHalf};
         4'd2:    stdRgb = {lvlNone, lvlHalf, lvlNone};
         4'd3:    stdRgb = {lvlNone, lvlHalf, lvlHalf};
         4'd4:    stdRgb = {lvlHalf, lvlNone, lvlNone};
         4'd5:    stdRgb = {lvlHalf, lvlNone, lvlHalf};
         4'd6:    stdRgb = {lvlHalf, lvlHalf, lvlNone};
         4'd7:    stdRgb = {lvlHalf, lvlHalf, lvlHalf};
         4'd9:    stdRgb = {lvlNone, lvlNone, lvlFull};
         4'd10:   stdRgb = {lvlNone, lvlFull, lvlNone};
         4'd11:   stdRgb = {lvlNone, lvlFull, lvlFull};
         4'd12:   stdRgb = {lvlFull, lvlNone, lvlNone};
         4'd13:   stdRgb = {lvlFull, lvlNone, lvlFull};
         4'd14:   stdRgb = {lvlFull, lvlFull, lvlNone};
         4'd15:   stdRgb = {lvlFull, lvlFull, lvlFull};
         // Black, bright or not
         default: stdRgb = {lvlNone, lvlNone, lvlNone};
      endcase
   end

endmodule

// File: design/ulaCpuPkg.sv
package ulaCpuPkg;

   // Z80 address and data buses
   typedef logic [15:0] cpuAddr_t;
   typedef logic [7:0]  cpuByte_t;

   // ULAplus register port value
   // Bit 6 selects config, bits 5..0 index the palette
   typedef logic [6:0] plusReg_t;

   // Entry number in the 64-colour palette
   typedef logic [5:0] paletteIdx_t;

endpackage

// File: design/ulaTop.sv
`timescale 1ns/1ns

module ulaTop (
   input  logic                   clk7,
   input  logic                   rst_n,
   // Z80 bus
   input  ulaCpuPkg::cpuAddr_t    a,
   input  logic                   iorqN,
   input  logic                   rdN,
   input  logic                   wrN,
   input  ulaCpuPkg::cpuByte_t    din,
   output ulaCpuPkg::cpuByte_t    dout,
   output logic                   intN,
   // Keyboard, tape and beeper
   input  logic                   ear,
   input  logic [4:0]             kbd,
   input  logic                   issue2Keyboard,
   output logic                   mic,
   output logic                   spk,
   // VRAM
   output ulaVideoPkg::vramAddr_t va,
   input  ulaVideoPkg::vramByte_t vramData,
   // Video out
   output ulaVideoPkg::colour3_t  r,
   output ulaVideoPkg::colour3_t  g,
   output ulaVideoPkg::colour3_t  b
);

   // Control strobes
   logic bitmapLoad;
   logic attrLoad;
   logic serialLoad;
   logic videoEnable;
   logic attrOutLoad;
   logic frameTick;

   // CPU register outputs
   ulaVideoPkg::colour3_t    border;
   logic                     paletteWrite;
   ulaCpuPkg::paletteIdx_t   paletteIdx;
   logic                     ulaPlusEnabled;
   ulaVideoPkg::plusColour_t paletteEntry;

   // Pixel path
   ulaVideoPkg::attr_t       attrNext;
   ulaVideoPkg::attr_t       attr;
   logic                     pixel;
   ulaVideoPkg::rgb9_t       stdRgb;
   ulaVideoPkg::plusColour_t plusRgb;

   rasterTiming rasterTiming_inst (
      .clk7(clk7), .rst_n(rst_n), .va(va),
      .bitmapLoad(bitmapLoad), .attrLoad(attrLoad), .serialLoad(serialLoad),
      .videoEnable(videoEnable), .attrOutLoad(attrOutLoad),
      .frameTick(frameTick), .intN(intN)
   );

   cpuPorts cpuPorts_inst (
      .clk7(clk7), .rst_n(rst_n), .a(a), .iorqN(iorqN), .rdN(rdN), .wrN(wrN),
      .din(din), .ear(ear), .kbd(kbd), .issue2Keyboard(issue2Keyboard),
      .paletteEntry(paletteEntry), .dout(dout), .mic(mic), .spk(spk),
      .border(border), .paletteWrite(paletteWrite), .paletteIdx(paletteIdx),
      .ulaPlusEnabled(ulaPlusEnabled)
   );

   videoFetch videoFetch_inst (
      .clk7(clk7), .rst_n(rst_n), .vramData(vramData), .border(border),
      .bitmapLoad(bitmapLoad), .attrLoad(attrLoad), .serialLoad(serialLoad),
      .videoEnable(videoEnable), .attrOutLoad(attrOutLoad),
      .attrNext(attrNext), .attr(attr), .pixel(pixel)
   );

   // Standard and ULAplus colour side by side
   stdColour stdColour_inst (
      .clk7(clk7), .rst_n(rst_n), .attr(attr), .pixel(pixel),
      .frameTick(frameTick), .stdRgb(stdRgb)
   );

   plusColour plusColour_inst (
      .clk7(clk7), .paletteWrite(paletteWrite), .paletteIdx(paletteIdx),
      .din(din), .attrNext(attrNext), .attrOutLoad(attrOutLoad),
      .pixel(pixel), .plusRgb(plusRgb), .paletteEntry(paletteEntry)
   );

   colourMerge colourMerge_inst (
      .clk7(clk7), .rst_n(rst_n), .stdRgb(stdRgb), .plusRgb(plusRgb),
      .ulaPlusEnabled(ulaPlusEnabled), .r(r), .g(g), .b(b)
   );

endmodule

// File: design/ulaVideoPkg.sv
package ulaVideoPkg;

   // Raster counters
   typedef logic [8:0] hCount_t;
   typedef logic [8:0] vCount_t;

   // 16 KB video memory
   typedef logic [13:0] vramAddr_t;
   typedef logic [7:0]  vramByte_t;

   // Flash, bright, paper[2:0], ink[2:0]
   typedef logic [7:0] attr_t;

   // Border, paper or ink colour as GRB
   typedef logic [2:0] colour3_t;

   // Bright plus GRB
   typedef logic [3:0] igrb_t;

   // GGGRRRBBB as sent to the DAC
   typedef logic [8:0] rgb9_t;

   // ULAplus palette entry, GGGRRRBB
   typedef logic [7:0] plusColour_t;

endpackage

// File: design/videoFetch.sv
`timescale 1ns/1ns

module videoFetch (
   input  logic                   clk7,
   input  logic                   rst_n,
   input  ulaVideoPkg::vramByte_t vramData,
   input  ulaVideoPkg::colour3_t  border,
   input  logic                   bitmapLoad,
   input  logic                   attrLoad,
   input  logic                   serialLoad,
   input  logic                   videoEnable,
   input  logic                   attrOutLoad,
   output ulaVideoPkg::attr_t     attrNext,
   output ulaVideoPkg::attr_t     attr,
   output logic                   pixel
);

   ulaVideoPkg::vramByte_t bitmapData;
   ulaVideoPkg::attr_t     attrData;
   ulaVideoPkg::vramByte_t serializer;

   //////////////////////////////
   // VRAM latches
   //////////////////////////////

   // Asynchronous VRAM, byte valid in the strobe cycle
   always_ff @(posedge clk7) begin
      if (bitmapLoad)
         bitmapData <= vramData;
      if (attrLoad)
         attrData <= vramData;
   end

   //////////////////////////////
   // Serialiser and attribute
   //////////////////////////////

   // MSB first, zeros shift in behind
   always_ff @(posedge clk7) begin
      if (!rst_n)
         serializer <= '0;
      else if (serialLoad)
         serializer <= bitmapData;
      else
         serializer <= {serializer[6:0], 1'b0};
   end

   assign pixel = serializer[7];

   // Border shows as paper, no flash or bright
   assign attrNext = videoEnable ? attrData : {2'b00, border, 3'b000};

   // Same edge as the serialiser load
   always_ff @(posedge clk7) begin
      if (!rst_n)
         attr <= '0;
      else if (attrOutLoad)
         attr <= attrNext;
   end

endmodule

// File: include/ula_settings.svh
`ifndef ULA_SETTINGS_SVH
`define ULA_SETTINGS_SVH

// Raster geometry in pixel clocks and lines
`define H_TOTAL         448
`define V_TOTAL         312

// Last column and line of the paper area
`define H_PAPER_END     255
`define V_PAPER_END     191

// Frame interrupt window
// 64 pixel clocks wide, which is 32 T-states
`define INT_LINE        248
`define INT_FIRST       2
`define INT_LAST        65

// ULAplus port addresses (fully decoded)
`define PLUS_ADDR_PORT  16'hBF3B
`define PLUS_DATA_PORT  16'hFF3B

// Red border after reset
`define BORDER_RESET    3'd2

`endif

// File: list.f
+incdir+include
design/ulaVideoPkg.sv
design/ulaCpuPkg.sv
design/rasterTiming.sv
design/cpuPorts.sv
design/videoFetch.sv
design/stdColour.sv
design/plusColour.sv
design/colourMerge.sv
design/ulaTop.sv
tb/ulaTb.sv

// File: tb/ulaTb.sv
`timescale 1ns/1ns
`include "ula_settings.svh"

module ulaTb;

   localparam int frameCycles = `H_TOTAL * `V_TOTAL;
   localparam int paperPixels = 256 * 192;
   // Frame tests need about 35 frames end to end
   localparam int timeoutCycles = 40 * frameCycles;

   // Table row kinds
   localparam int opWrite = 0;
   localparam int opRead  = 1;
   localparam int opKeys  = 2;

   logic                   clk7;
   logic                   rst_n;
   ulaCpuPkg::cpuAddr_t    a;
   logic                   iorqN;
   logic                   rdN;
   logic                   wrN;
   ulaCpuPkg::cpuByte_t    din;
   ulaCpuPkg::cpuByte_t    dout;
   logic                   intN;
   logic                   ear;
   logic [4:0]             kbd;
   logic                   issue2Keyboard;
   logic                   mic;
   logic                   spk;
   ulaVideoPkg::vramAddr_t va;
   ulaVideoPkg::vramByte_t vramData;
   ulaVideoPkg::colour3_t  r;
   ulaVideoPkg::colour3_t  g;
   ulaVideoPkg::colour3_t  b;

   // Asynchronous 16 KB VRAM model
   logic [7:0] vram [16384];

   int     cycleCount = 0;
   int     errorCount = 0;
   int     testErrors = 0;
   int     testsRun = 0;
   int     testsFailed = 0;
   integer seed;
   logic   spkModel;
   logic   micModel;

   // Per-window tallies
   int winTotal;
   int winInk;
   int winOther;
   int winLow;

   // Stimulus table columns
   int                  rowTest[$];
   int                  rowKind[$];
   ulaCpuPkg::cpuAddr_t rowAddr[$];
   ulaCpuPkg::cpuByte_t rowData[$];
   ulaCpuPkg::cpuByte_t rowExp[$];

   ulaTop ulaTop_inst (
      .clk7(clk7), .rst_n(rst_n), .a(a), .iorqN(iorqN), .rdN(rdN), .wrN(wrN),
      .din(din), .dout(dout), .intN(intN), .ear(ear), .kbd(kbd),
      .issue2Keyboard(issue2Keyboard), .mic(mic), .spk(spk),
      .va(va), .vramData(vramData), .r(r), .g(g), .b(b)
   );

   assign vramData = vram[va];

   initial begin
      clk7 = 1'b0;
      forever #2 clk7 = ~clk7;
   end

   // Run limit
   always @(posedge clk7) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= timeoutCycles) begin
         $display("Timeout after %0d cycles, the tests did not finish", cycleCount);
         $display(">>> FAIL");
         $finish;
      end
   end

   //////////////////////////////
   // Expected colours
   //////////////////////////////

   // Half level 101 and full level 111 on each GRB bit
   function automatic ulaVideoPkg::rgb9_t stdTable(input logic bright,
                                                   input ulaVideoPkg::colour3_t grb);
      ulaVideoPkg::colour3_t level;
      begin
         level = bright ? 3'b111 : 3'b101;
         stdTable = {grb[2] ? level : 3'b000,
                     grb[1] ? level : 3'b000,
                     grb[0] ? level : 3'b000};
      end
   endfunction

   // GGGRRRBB with blue as B1 B0 B1
   function automatic ulaVideoPkg::rgb9_t plusTo9(input ulaVideoPkg::plusColour_t p);
      plusTo9 = {p[7:2], p[1:0], p[1]};
   endfunction

   //////////////////////////////
   // Z80 bus
   //////////////////////////////

   task automatic busWrite(input ulaCpuPkg::cpuAddr_t addr, input ulaCpuPkg::cpuByte_t data);
      @(posedge clk7);
      #1;
      a = addr;
      din = data;
      iorqN = 1'b0;
      wrN = 1'b0;
      @(posedge clk7);
      #1;
      iorqN = 1'b1;
      wrN = 1'b1;
   endtask

   // Combinational dout sampled mid-cycle
   task automatic busRead(input ulaCpuPkg::cpuAddr_t addr, output ulaCpuPkg::cpuByte_t data);
      @(posedge clk7);
      #1;
      a = addr;
      iorqN = 1'b0;
      rdN = 1'b0;
      @(negedge clk7);
      data = dout;
      @(posedge clk7);
      #1;
      iorqN = 1'b1;
      rdN = 1'b1;
   endtask

   task automatic driveKeys(input logic issue2, input logic [4:0] keys, input logic earBit);
      @(posedge clk7);
      #1;
      issue2Keyboard = issue2;
      kbd = keys;
      ear = earBit;
   endtask

   task automatic checkByte(input string name, input ulaCpuPkg::cpuByte_t got,
                            input ulaCpuPkg::cpuByte_t exp);
      if (got !== exp) begin
         $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
         errorCount++;
      end
   endtask

   //////////////////////////////
   // Stimulus table
   //////////////////////////////

   task automatic addRow(input int test, input int kind, input ulaCpuPkg::cpuAddr_t addr,
                         input ulaCpuPkg::cpuByte_t data, input ulaCpuPkg::cpuByte_t exp);
      rowTest.push_back(test);
      rowKind.push_back(kind);
      rowAddr.push_back(addr);
      rowData.push_back(data);
      rowExp.push_back(exp);
   endtask

   // Key rows carry issue2Keyboard in data bit 0
   // Their expected value comes from the EAR rule at run time
   task automatic buildTable;
      addRow(1, opWrite, 16'h00FE, 8'h10, 8'h00);
      addRow(1, opKeys,  16'h00FE, 8'h00, 8'h00);
      addRow(1, opKeys,  16'h00FE, 8'h01, 8'h00);
      addRow(1, opKeys,  16'h00FE, 8'h00, 8'h00);
      addRow(1, opKeys,  16'h00FE, 8'h01, 8'h00);
      addRow(1, opWrite, 16'h00FE, 8'h08, 8'h00);
      addRow(1, opKeys,  16'h00FE, 8'h00, 8'h00);
      addRow(1, opKeys,  16'h00FE, 8'h01, 8'h00);
      addRow(1, opKeys,  16'h00FE, 8'h00, 8'h00);
      addRow(1, opKeys,  16'h00FE, 8'h01, 8'h00);
      addRow(1, opWrite, 16'h7FFE, 8'h18, 8'h00);
      addRow(1, opKeys,  16'hFEFE, 8'h00, 8'h00);
      addRow(1, opKeys,  16'hFEFE, 8'h01, 8'h00);
      addRow(1, opWrite, 16'h00FE, 8'h00, 8'h00);
      addRow(1, opKeys,  16'h00FE, 8'h00, 8'h00);
      addRow(1, opKeys,  16'h00FE, 8'h01, 8'h00);
      addRow(1, opRead,  16'h00FF, 8'h00, 8'hFF);
      addRow(1, opRead,  16'h7FFD, 8'h00, 8'hFF);
      // Register readback followed by four palette entries and config
      addRow(2, opWrite, `PLUS_ADDR_PORT, 8'h25, 8'h00);
      addRow(2, opRead,  `PLUS_ADDR_PORT, 8'h00, 8'h25);
      addRow(2, opWrite, `PLUS_ADDR_PORT, 8'h01, 8'h00);
      addRow(2, opWrite, `PLUS_DATA_PORT, 8'h5A, 8'h00);
      addRow(2, opRead,  `PLUS_DATA_PORT, 8'h00, 8'h5A);
      addRow(2, opWrite, `PLUS_ADDR_PORT, 8'h10, 8'h00);
      addRow(2, opWrite, `PLUS_DATA_PORT, 8'hC3, 8'h00);
      addRow(2, opRead,  `PLUS_DATA_PORT, 8'h00, 8'hC3);
      addRow(2, opWrite, `PLUS_ADDR_PORT, 8'h2F, 8'h00);
      addRow(2, opWrite, `PLUS_DATA_PORT, 8'h81, 8'h00);
      addRow(2, opRead,  `PLUS_DATA_PORT, 8'h00, 8'h81);
      addRow(2, opWrite, `PLUS_ADDR_PORT, 8'h3E, 8'h00);
      addRow(2, opWrite, `PLUS_DATA_PORT, 8'h3C, 8'h00);
      addRow(2, opRead,  `PLUS_DATA_PORT, 8'h00, 8'h3C);
      addRow(2, opWrite, `PLUS_ADDR_PORT, 8'h01, 8'h00);
      addRow(2, opRead,  `PLUS_DATA_PORT, 8'h00, 8'h5A);
      // Config select with index 1 so a stray palette write would land on 0x5A
      addRow(2, opWrite, `PLUS_ADDR_PORT, 8'h41, 8'h00);
      addRow(2, opRead,  `PLUS_ADDR_PORT, 8'h00, 8'h41);
      addRow(2, opWrite, `PLUS_DATA_PORT, 8'h01, 8'h00);
      addRow(2, opRead,  `PLUS_DATA_PORT, 8'h00, 8'h01);
      addRow(2, opWrite, `PLUS_DATA_PORT, 8'h00, 8'h00);
      addRow(2, opRead,  `PLUS_DATA_PORT, 8'h00, 8'h00);
      // Config writes leave the palette alone
      addRow(2, opWrite, `PLUS_ADDR_PORT, 8'h01, 8'h00);
      addRow(2, opRead,  `PLUS_DATA_PORT, 8'h00, 8'h5A);
   endtask

   task automatic runTable(input int testNo);
      ulaCpuPkg::cpuByte_t got;
      logic [31:0]         rnd;
      logic [4:0]          keys;
      logic                earBit;
      logic                issue2;
      logic                earExp;
      begin
         for (int i = 0; i < rowKind.size(); i++) begin
            if (rowTest[i] == testNo) begin
               case (rowKind[i])
                  opWrite: begin
                     busWrite(rowAddr[i], rowData[i]);
                     // Track speaker and mic for the EAR rule
                     if (!rowAddr[i][0]) begin
                        spkModel = rowData[i][4];
                        micModel = rowData[i][3];
                        checkByte("{spk, mic}", {6'b000000, spk, mic},
                                  {6'b000000, spkModel, micModel});
                     end
                  end
                  opRead: begin
                     busRead(rowAddr[i], got);
                     checkByte("dout", got, rowExp[i]);
                  end
                  default: begin
                     rnd = $random(seed);
                     keys = rnd[4:0];
                     earBit = rnd[5];
                     issue2 = rowData[i][0];
                     driveKeys(issue2, keys, earBit);
                     busRead(rowAddr[i], got);
                     earExp = issue2 ? (earBit ^ (spkModel | micModel)) : (earBit ^ spkModel);
                     checkByte("dout", got, {1'b1, earExp, 1'b1, keys});
                  end
               endcase
            end
         end
      end
   endtask

   //////////////////////////////
   // Frame windows
   //////////////////////////////

   // Stops on the first low sample of intN
   task automatic waitIntFall;
      logic lastInt;
      begin
         @(negedge clk7);
         lastInt = intN;
         @(negedge clk7);
         while (!(lastInt && !intN)) begin
            lastInt = intN;
            @(negedge clk7);
         end
      end
   endtask

   // Starts on a falling edge of intN and stops on the next one
   task automatic countWindow(input logic checkRgb, input ulaVideoPkg::rgb9_t otherRgb,
                              input ulaVideoPkg::rgb9_t inkRgb);
      logic               lastInt;
      logic               rgbReported;
      logic               vaReported;
      ulaVideoPkg::rgb9_t rgbNow;
      begin
         winTotal = 0;
         winInk = 0;
         winOther = 0;
         winLow = 0;
         rgbReported = 1'b0;
         vaReported = 1'b0;
         do begin
            rgbNow = {g, r, b};
            winTotal++;
            if (!intN)
               winLow++;
            if (va >= 14'h1B00 && !vaReported) begin
               $display("** Error: va = 0x%h, expected below 0x1b00", va);
               errorCount++;
               vaReported = 1'b1;
            end
            if (rgbNow == otherRgb)
               winOther++;
            else if (rgbNow == inkRgb)
               winInk++;
            else if (checkRgb && !rgbReported) begin
               $display("** Error: rgb = 0x%h, expected 0x%h or 0x%h", rgbNow, otherRgb, inkRgb);
               errorCount++;
               rgbReported = 1'b1;
            end
            lastInt = intN;
            @(negedge clk7);
         end while (!(lastInt && !intN));
      end
   endtask

   // All bitmap bytes one value, all attributes another
   task automatic fillScreen(input ulaVideoPkg::vramByte_t bitmap, input ulaVideoPkg::attr_t at);
      for (int i = 0; i < 16'h1800; i++)
         vram[i] = bitmap;
      for (int i = 16'h1800; i < 16'h1B00; i++)
         vram[i] = at;
   endtask

   task automatic endTest(input string name);
      testsRun++;
      if (errorCount == testErrors) begin
         $display("Test %0d %s: ok", testsRun, name);
      end else begin
         testsFailed++;
         $display("Test %0d %s: %0d errors", testsRun, name, errorCount - testErrors);
      end
      testErrors = errorCount;
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      ulaVideoPkg::colour3_t borderColour;
      ulaVideoPkg::rgb9_t    paperRgb;
      ulaVideoPkg::rgb9_t    inkRgb;
      ulaVideoPkg::rgb9_t    plusRgb;
      int                    prevInk;
      int                    runLen;
      int                    edges;
      int                    windows;

      rst_n = 1'b0;
      a = '0;
      iorqN = 1'b1;
      rdN = 1'b1;
      wrN = 1'b1;
      din = '0;
      ear = 1'b0;
      kbd = 5'h1F;
      issue2Keyboard = 1'b0;
      seed = 32'h644e_a795;
      spkModel = 1'b0;
      micModel = 1'b0;
      // Pattern spans all 14 address bits
      for (int i = 0; i < 16384; i++)
         vram[i] = 8'(i) ^ 8'(i >> 6);
      buildTable();

      // Reset held for 16 rising edges
      repeat (15) @(posedge clk7);
      @(negedge clk7);
      if (intN !== 1'b1) begin
         $display("** Error: intN = 0x%h, expected 0x1", intN);
         errorCount++;
      end
      if ({mic, spk} !== 2'b00) begin
         $display("** Error: {mic, spk} = 0x%h, expected 0x0", {mic, spk});
         errorCount++;
      end
      if ({g, r, b} !== 9'h000) begin
         $display("** Error: rgb = 0x%h, expected 0x000", {g, r, b});
         errorCount++;
      end
      @(posedge clk7);
      #1;
      rst_n = 1'b1;

      runTable(1);
      endTest("port 0xFE reads");
      runTable(2);
      endTest("ULAplus readback");

      // Interrupt pulse width and frame period
      waitIntFall();
      for (int k = 0; k < 2; k++) begin
         countWindow(1'b0, '0, '0);
         if (winLow != 64) begin
            $display("intN stayed low for %0d cycles instead of 64", winLow);
            errorCount++;
         end
         if (winTotal != frameCycles) begin
            $display("intN falls %0d cycles apart instead of %0d", winTotal, frameCycles);
            errorCount++;
         end
      end
      endTest("interrupt timing");

      // Paper matches a cyan border
      borderColour = 3'd5;
      paperRgb = stdTable(1'b0, borderColour);
      fillScreen(8'h00, {2'b00, borderColour, 3'd0});
      busWrite(16'h00FE, {5'b00000, borderColour});
      waitIntFall();
      countWindow(1'b1, paperRgb, paperRgb);
      if (winOther != frameCycles) begin
         $display("%0d samples showed the border colour instead of %0d", winOther, frameCycles);
         errorCount++;
      end
      // Solid bitmap in bright yellow ink
      // Counted in the very next window
      inkRgb = stdTable(1'b1, 3'd6);
      fillScreen(8'hFF, {2'b01, borderColour, 3'd6});
      countWindow(1'b1, paperRgb, inkRgb);
      if (winInk != paperPixels || winTotal != frameCycles) begin
         $display("%0d ink samples in a %0d cycle window, expected %0d in %0d",
                  winInk, winTotal, paperPixels, frameCycles);
         errorCount++;
      end
      endTest("standard colours");

      // Flash swaps ink and paper every 16 frames
      inkRgb = stdTable(1'b0, 3'd6);
      fillScreen(8'hFF, {2'b10, borderColour, 3'd6});
      countWindow(1'b1, paperRgb, inkRgb);
      prevInk = winInk;
      runLen = 0;
      edges = 0;
      windows = 1;
      while (edges < 2 && windows < 34) begin
         countWindow(1'b1, paperRgb, inkRgb);
         windows++;
         if (winInk != 0 && winInk != paperPixels) begin
            $display("%0d ink samples in a flash window, expected 0 or %0d",
                     winInk, paperPixels);
            errorCount++;
         end
         if (winInk == prevInk) begin
            runLen++;
         end else begin
            if (edges == 1 && runLen != 16) begin
               $display("Flash phase lasted %0d frames instead of 16", runLen);
               errorCount++;
            end
            edges++;
            runLen = 1;
         end
         prevInk = winInk;
      end
      if (edges < 2) begin
         $display("Flash phase changed %0d times in %0d frames, expected 2", edges, windows);
         errorCount++;
      end
      endTest("flash");

      // Palette entry 8 plus border drives paper and border alike
      plusRgb = plusTo9(8'hB6);
      fillScreen(8'h00, {2'b00, borderColour, 3'd0});
      busWrite(`PLUS_ADDR_PORT, {2'b00, 6'(6'd8 + 6'(borderColour))});
      busWrite(`PLUS_DATA_PORT, 8'hB6);
      busWrite(`PLUS_ADDR_PORT, 8'h40);
      busWrite(`PLUS_DATA_PORT, 8'h01);
      waitIntFall();
      countWindow(1'b1, plusRgb, plusRgb);
      if (winOther != frameCycles) begin
         $display("%0d samples showed the palette colour instead of %0d", winOther, frameCycles);
         errorCount++;
      end
      endTest("ULAplus colours");

      $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
               testsRun, testsRun - testsFailed, testsFailed, errorCount);
      if (errorCount == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule
